//--- hdl/router_pkg.sv
package router_pkg;

    // router ports, numbered as in the mesh
    localparam int num_ports  = 5;
    localparam int port_local = 0;
    localparam int port_east  = 1;
    localparam int port_north = 2;  // toward smaller y
    localparam int port_west  = 3;
    localparam int port_south = 4;  // toward larger y
    localparam int port_w     = 3;

    localparam int flit_w  = 32;
    localparam int coord_w = 4;

    // input buffer depth, also the credits each downstream port starts with
    localparam int buf_depth = 4;
    localparam int crdt_w    = 3;   // holds 0..buf_depth

    // top two bits of every flit
    typedef enum logic [1:0] {
        kind_head   = 2'b00,
        kind_body   = 2'b01,
        kind_tail   = 2'b10,
        kind_single = 2'b11   // head and tail in one flit
    } flit_kind_t;

    // one flit word, read as a head flit or as a body/tail flit
    typedef union packed {
        struct packed {
            flit_kind_t                         kind;
            logic [coord_w-1:0]                 dest_x;
            logic [coord_w-1:0]                 dest_y;
            logic [flit_w-2-2*coord_w-1:0]      payload;  // 22 bits
        } head;
        struct packed {
            flit_kind_t                         kind;
            logic [flit_w-3:0]                  payload;  // 30 bits
        } body;
    } flit_t;

endpackage

//--- hdl/input_port.sv
`timescale 1ns/1ps

module input_port import router_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  flit_t                flit_in,
    input  logic                 flit_wr,
    input  logic                 pop,
    input  logic [coord_w-1:0]   router_x,
    input  logic [coord_w-1:0]   router_y,
    output flit_t                head_flit,
    output logic                 head_valid,
    output logic [num_ports-1:0] req_port,   // one-hot output request
    output logic                 credit_out
);

    // buf_depth is a power of two, pointers wrap on their own
    flit_t                          mem [buf_depth];
    logic [$clog2(buf_depth)-1:0]   wr_ptr;
    logic [$clog2(buf_depth)-1:0]   rd_ptr;
    logic [crdt_w-1:0]              count;

    logic [port_w-1:0]  cur_route;   // decision for the flit now at the head
    logic [port_w-1:0]  route_q;     // held for the rest of the packet
    logic [port_w-1:0]  route;
    logic               head_is_hdr;

    always_ff @(posedge clk) begin
        if (flit_wr) begin
            mem[wr_ptr] <= flit_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (flit_wr) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({flit_wr, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_flit   = mem[rd_ptr];
    assign head_valid  = (count != '0);
    assign head_is_hdr = (head_flit.head.kind == kind_head) ||
                         (head_flit.head.kind == kind_single);

    // XY routing: resolve x first, then y, local once both match
    always_comb begin
        if (head_flit.head.dest_x > router_x) begin
            cur_route = port_w'(port_east);
        end else if (head_flit.head.dest_x < router_x) begin
            cur_route = port_w'(port_west);
        end else if (head_flit.head.dest_y > router_y) begin
            cur_route = port_w'(port_south);
        end else if (head_flit.head.dest_y < router_y) begin
            cur_route = port_w'(port_north);
        end else begin
            cur_route = port_w'(port_local);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            route_q <= port_w'(port_local);
        end else if (pop && head_is_hdr) begin
            route_q <= cur_route;  // body and tail follow the head
        end
    end

    assign route    = head_is_hdr ? cur_route : route_q;
    assign req_port = head_valid ? (num_ports'(1) << route) : '0;

    // one slot freed per pop, returned upstream a cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_out <= 1'b0;
        end else begin
            credit_out <= pop;
        end
    end

endmodule

//--- hdl/switch_alloc.sv
`timescale 1ns/1ps

module switch_alloc import router_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [num_ports-1:0] head_valid,
    input  logic [num_ports-1:0] req_port [num_ports],  // per input, one-hot over outputs
    input  flit_kind_t           head_kind [num_ports],
    input  logic [num_ports-1:0] has_credit,
    output logic [num_ports-1:0] pop,
    output logic [num_ports-1:0] grant [num_ports]      // per output, one-hot over inputs
);

    logic [num_ports-1:0] out_req [num_ports];   // requests seen by each output
    logic [num_ports-1:0] gnt_c   [num_ports];
    logic [num_ports-1:0] owner   [num_ports];   // input holding the wormhole
    logic [port_w-1:0]    last    [num_ports];   // last winner, for rotation
    logic [port_w-1:0]    win_idx [num_ports];
    logic [num_ports-1:0] locked;
    logic [num_ports-1:0] win_head;
    logic [num_ports-1:0] win_tail;

    // first requester after the last winner, wrapping around
    function automatic logic [num_ports-1:0] rr_pick(
        input logic [num_ports-1:0] req,
        input logic [port_w-1:0]    prev
    );
        logic [num_ports-1:0] gnt;
        int                   idx;
        gnt = '0;
        for (int k = 1; k <= num_ports; k++) begin
            idx = (int'(prev) + k) % num_ports;
            if (req[idx] && (gnt == '0)) gnt[idx] = 1'b1;
        end
        return gnt;
    endfunction

    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            for (int i = 0; i < num_ports; i++) begin
                out_req[o][i] = head_valid[i] & req_port[i][o];
            end
        end
    end

    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            if (!has_credit[o]) begin
                gnt_c[o] = '0;
            end else if (locked[o]) begin
                gnt_c[o] = out_req[o] & owner[o];  // only the packet in flight
            end else begin
                gnt_c[o] = rr_pick(out_req[o], last[o]);
            end
            win_idx[o]  = '0;
            win_head[o] = 1'b0;
            win_tail[o] = 1'b0;
            for (int i = 0; i < num_ports; i++) begin
                if (gnt_c[o][i]) begin
                    win_idx[o]  = port_w'(i);
                    win_head[o] = (head_kind[i] == kind_head);
                    win_tail[o] = (head_kind[i] == kind_tail) || (head_kind[i] == kind_single);
                end
            end
        end
    end

    // an input asks for one output at most, so no input-side conflict
    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            pop[i] = 1'b0;
            for (int o = 0; o < num_ports; o++) begin
                pop[i] = pop[i] | gnt_c[o][i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= '0;
            for (int o = 0; o < num_ports; o++) begin
                owner[o] <= '0;
                last[o]  <= '0;
                grant[o] <= '0;
            end
        end else begin
            for (int o = 0; o < num_ports; o++) begin
                grant[o] <= gnt_c[o];   // stage 2 select
                if (gnt_c[o] != '0) begin
                    last[o] <= win_idx[o];
                    if (win_head[o]) begin
                        locked[o] <= 1'b1;
                        owner[o]  <= gnt_c[o];
                    end else if (win_tail[o]) begin
                        locked[o] <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

//--- hdl/output_credit.sv
`timescale 1ns/1ps

module output_credit import router_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [num_ports-1:0] credit_in,   // slot freed downstream
    input  logic [num_ports-1:0] sent,        // registered grant, flit leaving
    output logic [num_ports-1:0] has_credit
);

    logic [crdt_w-1:0] cnt [num_ports];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int o = 0; o < num_ports; o++) begin
                cnt[o] <= crdt_w'(buf_depth);
            end
        end else begin
            for (int o = 0; o < num_ports; o++) begin
                case ({credit_in[o], sent[o]})
                    2'b10:   cnt[o] <= cnt[o] + 1'b1;
                    2'b01:   cnt[o] <= cnt[o] - 1'b1;
                    default: cnt[o] <= cnt[o];   // none, or both cancel
                endcase
            end
        end
    end

    // the flit granted last cycle is not yet counted, so leave room for it
    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            has_credit[o] = (cnt[o] > crdt_w'(sent[o]));
        end
    end

endmodule

//--- hdl/crossbar.sv
`timescale 1ns/1ps

module crossbar import router_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [num_ports-1:0] grant [num_ports],  // registered, one-hot over inputs
    input  flit_t                flit_in [num_ports],
    output flit_t                flit_out [num_ports],
    output logic [num_ports-1:0] flit_wr
);

    flit_t sel [num_ports];

    // and-or mux per output, grants are one-hot
    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            sel[o] = '0;
            for (int i = 0; i < num_ports; i++) begin
                if (grant[o][i]) sel[o] = flit_in[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < num_ports; o++) begin
            flit_out[o] <= sel[o];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flit_wr <= '0;
        end else begin
            for (int o = 0; o < num_ports; o++) begin
                flit_wr[o] <= |grant[o];
            end
        end
    end

endmodule

//--- hdl/credit_release_gen.sv
`timescale 1ns/1ps

module credit_release_gen import router_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic en,
    output logic credit_out
);

    logic [crdt_w-1:0] counter;
    logic              cnt_zero;
    logic              cnt_max;
    logic              cnt_incr;

    assign cnt_zero = (counter == '0);
    assign cnt_max  = (counter == crdt_w'(buf_depth));
    // start on en, then run to the end without it; stays at max until reset
    assign cnt_incr = (en & cnt_zero) | (~cnt_zero & ~cnt_max);

    always_ff @(posedge clk) begin
        if (rst) begin
            counter    <= '0;
            credit_out <= 1'b0;
        end else begin
            credit_out <= cnt_incr;   // one credit per step
            if (cnt_incr) begin
                counter <= counter + 1'b1;
            end
        end
    end

endmodule

//--- hdl/router_two_stage.sv
`timescale 1ns/1ps

module router_two_stage import router_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  flit_t                flit_in [num_ports],
    input  logic [num_ports-1:0] flit_wr_in,
    output logic [num_ports-1:0] credit_out,         // to upstream
    output flit_t                flit_out [num_ports],
    output logic [num_ports-1:0] flit_wr_out,
    input  logic [num_ports-1:0] credit_in,          // from downstream
    input  logic [num_ports-1:0] credit_release_en,
    // own mesh position, an input so every router is the same RTL
    input  logic [coord_w-1:0]   router_x,
    input  logic [coord_w-1:0]   router_y
);

    flit_t                head_flit [num_ports];
    flit_t                pop_flit  [num_ports];   // stage 1 to stage 2
    logic [num_ports-1:0] head_valid;
    logic [num_ports-1:0] req_port  [num_ports];
    flit_kind_t           head_kind [num_ports];
    logic [num_ports-1:0] pop;
    logic [num_ports-1:0] grant     [num_ports];
    logic [num_ports-1:0] has_credit;
    logic [num_ports-1:0] sent;
    logic [num_ports-1:0] iport_credit;
    logic [num_ports-1:0] release_credit;

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        input_port u_input_port (
            .clk        (clk),
            .rst        (rst),
            .flit_in    (flit_in[p]),
            .flit_wr    (flit_wr_in[p]),
            .pop        (pop[p]),
            .router_x   (router_x),
            .router_y   (router_y),
            .head_flit  (head_flit[p]),
            .head_valid (head_valid[p]),
            .req_port   (req_port[p]),
            .credit_out (iport_credit[p])
        );

        // only a local endpoint ever raises en
        credit_release_gen u_credit_release (
            .clk        (clk),
            .rst        (rst),
            .en         (credit_release_en[p]),
            .credit_out (release_credit[p])
        );

        assign head_kind[p]  = head_flit[p].head.kind;  // same bits in both views
        assign credit_out[p] = iport_credit[p] | release_credit[p];
        assign sent[p]       = |grant[p];
    end

    switch_alloc u_switch_alloc (
        .clk        (clk),
        .rst        (rst),
        .head_valid (head_valid),
        .req_port   (req_port),
        .head_kind  (head_kind),
        .has_credit (has_credit),
        .pop        (pop),
        .grant      (grant)
    );

    output_credit u_output_credit (
        .clk        (clk),
        .rst        (rst),
        .credit_in  (credit_in),
        .sent       (sent),
        .has_credit (has_credit)
    );

    // capture the winning head flit as it leaves its buffer
    always_ff @(posedge clk) begin
        for (int i = 0; i < num_ports; i++) begin
            if (pop[i]) pop_flit[i] <= head_flit[i];
        end
    end

    crossbar u_crossbar (
        .clk      (clk),
        .rst      (rst),
        .grant    (grant),
        .flit_in  (pop_flit),
        .flit_out (flit_out),
        .flit_wr  (flit_wr_out)
    );

endmodule

//--- bench/router_assertions.sv
`timescale 1ns/1ps

module router_assertions import router_pkg::*; (
    input logic                 clk,
    input logic                 rst,
    input flit_t                flit_out [num_ports],
    input logic [num_ports-1:0] flit_wr_out,
    input logic [num_ports-1:0] head_valid,
    input logic [num_ports-1:0] iport_credit
);

    logic [num_ports-1:0] in_pkt;      // head sent and tail not yet
    int                   fail_count;  // failed assertions so far

    always_ff @(posedge clk) begin
        if (rst) begin
            in_pkt <= '0;
        end else begin
            for (int o = 0; o < num_ports; o++) begin
                if (flit_wr_out[o] && flit_out[o].body.kind == kind_head) begin
                    in_pkt[o] <= 1'b1;
                end else if (flit_wr_out[o] && (flit_out[o].body.kind == kind_tail ||
                             flit_out[o].body.kind == kind_single)) begin
                    in_pkt[o] <= 1'b0;
                end
            end
        end
    end

    // reset edges and the first edge after them
    wr_quiet_at_reset: assert property (@(posedge clk)
        ($past(rst) || $past(rst, 2)) |-> (flit_wr_out == '0))
        else begin
            fail_count++;
            $error("flit_wr_out active during or right after reset");
        end

    for (genvar o = 0; o < num_ports; o++) begin : g_out
        body_after_head: assert property (@(posedge clk) disable iff (rst)
            flit_wr_out[o] && (flit_out[o].body.kind == kind_body ||
            flit_out[o].body.kind == kind_tail) |-> in_pkt[o])
            else begin
                fail_count++;
                $error("output %0d sent a body or tail flit with no open packet", o);
            end

        credit_needs_flit: assert property (@(posedge clk) disable iff (rst)
            iport_credit[o] |-> $past(head_valid[o]))
            else begin
                fail_count++;
                $error("input %0d returned a credit while its buffer was empty", o);
            end
    end

endmodule

//--- bench/router_tb.sv
`timescale 1ns/1ps

module router_tb import router_pkg::*; ();

    localparam int total_flits = 89;   // upper bound over all tests
    localparam int wr_to_out   = 3;    // write edge, then two pipeline edges

    logic                 clk, rst;
    flit_t                flit_in  [num_ports];
    flit_t                flit_out [num_ports];
    logic [num_ports-1:0] flit_wr_in, credit_out, flit_wr_out, credit_in, credit_release_en;
    logic [coord_w-1:0]   router_x, router_y;

    flit_t       send_q [num_ports][$];
    flit_t       exp_q  [num_ports*num_ports][$];   // per input and output pair
    int          up_crd[num_ports], crd_pulses[num_ports], rel_pulses[num_ports];
    int          wr_count[num_ports], wr_cyc[num_ports];
    int          rx_cnt[num_ports], out_cyc[num_ports], owed[num_ports], gap[num_ports];
    int          cur_src[num_ports];
    int          hold_port = -1;
    int          cyc = 0, checks = 0, errors = 0;
    logic [31:0] lfsr = 32'h9da7_9ff2;

    router_two_stage UUT (.*);

    bind router_two_stage router_assertions u_assertions (
        .clk          (clk),
        .rst          (rst),
        .flit_out     (flit_out),
        .flit_wr_out  (flit_wr_out),
        .head_valid   (head_valid),
        .iport_credit (iport_credit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // XY rule with x resolved first; y grows toward south
    function automatic int expected_port(input int rx, input int ry, input int dx, input int dy);
        if (dx > rx) return port_east;
        if (dx < rx) return port_west;
        if (dy > ry) return port_south;
        if (dy < ry) return port_north;
        return port_local;
    endfunction

    task automatic check_flit(input flit_t got, input flit_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got flit %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // source input rides in the low three payload bits of every flit
    task automatic queue_packet(input int src, input int len, input int dx, input int dy);
        flit_t f;
        int    o;
        o = expected_port(int'(router_x), int'(router_y), dx, dy);
        for (int k = 0; k < len; k++) begin
            f = '0;
            if (k == 0) begin
                f.head.kind    = (len == 1) ? kind_single : kind_head;
                f.head.dest_x  = coord_w'(dx);
                f.head.dest_y  = coord_w'(dy);
                f.head.payload = {19'(rand_bits(19)), 3'(src)};
            end else begin
                f.body.kind    = (k == len - 1) ? kind_tail : kind_body;
                f.body.payload = {27'(rand_bits(27)), 3'(src)};
            end
            send_q[src].push_back(f);
            exp_q[src*num_ports + o].push_back(f);
        end
    endtask

    task automatic drain();
        int busy;
        busy = 1;
        while (busy != 0) begin
            @(posedge clk);
            busy = 0;
            for (int i = 0; i < num_ports; i++) busy += send_q[i].size() + owed[i];
            for (int k = 0; k < num_ports*num_ports; k++) busy += exp_q[k].size();
        end
        repeat (4) @(posedge clk);
    endtask

    // upstream writes only while holding a credit
    initial begin : drive_inputs
        flit_wr_in = '0;
        for (int i = 0; i < num_ports; i++) begin
            flit_in[i] = '0;
            up_crd[i]  = buf_depth;
        end
        forever begin
            @(negedge clk);
            for (int i = 0; i < num_ports; i++) begin
                if (credit_out[i] && !rst) begin
                    up_crd[i]++;
                    crd_pulses[i]++;
                end
                flit_wr_in[i] = 1'b0;
                if (!rst && send_q[i].size() > 0 && up_crd[i] > 0) begin
                    flit_in[i]    = send_q[i].pop_front();
                    flit_wr_in[i] = 1'b1;
                    up_crd[i]--;
                    wr_count[i]++;
                    wr_cyc[i] = cyc;
                end
            end
        end
    end

    // scoreboard plus downstream credit model
    initial begin : compare_outputs
        flit_t got;
        int    src;
        credit_in = '0;
        for (int o = 0; o < num_ports; o++) cur_src[o] = -1;
        forever begin
            @(negedge clk);
            for (int o = 0; o < num_ports; o++) begin
                credit_in[o] = 1'b0;
                if (flit_wr_out[o]) begin
                    got = flit_out[o];
                    src = int'(got.body.payload[2:0]);
                    rx_cnt[o]++;
                    out_cyc[o] = cyc;
                    owed[o]++;
                    if (got.body.kind == kind_head || got.body.kind == kind_single) begin
                        if (cur_src[o] >= 0) begin
                            errors++;
                            $display("output %0d started a packet inside another one", o);
                        end
                        cur_src[o] = (got.body.kind == kind_head) ? src : -1;
                    end else begin
                        if (cur_src[o] != src) begin
                            errors++;
                            $display("output %0d mixed flits of two packets", o);
                        end
                        if (got.body.kind == kind_tail) cur_src[o] = -1;
                    end
                    if (src >= num_ports || exp_q[src*num_ports + o].size() == 0) begin
                        errors++;
                        $display("output %0d delivered a flit that was never sent there", o);
                    end else begin
                        check_flit(got, exp_q[src*num_ports + o].pop_front(),
                                   $sformatf("output %0d", o));
                    end
                end
                if (o != hold_port && owed[o] > 0) begin
                    if (gap[o] == 0) begin
                        credit_in[o] = 1'b1;
                        owed[o]--;
                        gap[o] = int'(rand_bits(2));
                    end else begin
                        gap[o]--;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        repeat (total_flits * 20 + 400) @(posedge clk);
        $display("timeout, traffic did not drain in time");
        $display("Result: FAILED");
        $finish;
    end

    initial begin : run_tests
        int dxs[5] = '{3, 2, 1, 2, 2};
        int dys[5] = '{2, 1, 2, 3, 2};
        int mark, base;
        rst = 1'b1;
        credit_release_en = '0;
        router_x = coord_w'(2);
        router_y = coord_w'(2);
        repeat (8) @(posedge clk);
        @(negedge clk) rst = 1'b0;
        @(posedge clk);

        mark = errors;
        for (int d = 0; d < 5; d++) begin
            queue_packet(port_local, 1, dxs[d], dys[d]);
            drain();
            check_count(out_cyc[expected_port(2, 2, dxs[d], dys[d])] - wr_cyc[port_local],
                        wr_to_out, "latency to output");
        end
        $display("test 1 single flits: %0d errors", errors - mark);

        mark = errors;
        for (int i = 0; i < num_ports; i++) begin
            for (int p = 0; p < 3; p++) begin
                queue_packet(i, 1 + int'(rand_bits(2)), int'(rand_bits(3)) % 5,
                             int'(rand_bits(3)) % 5);
            end
        end
        drain();
        $display("test 2 random packets: %0d errors", errors - mark);

        mark = errors;
        for (int p = 0; p < 2; p++) begin
            queue_packet(port_east, 4, 2, 2);
            queue_packet(port_west, 4, 2, 2);
        end
        drain();
        $display("test 3 contention: %0d errors", errors - mark);

        mark = errors;
        hold_port = port_east;
        base = rx_cnt[port_east];
        queue_packet(port_local, 8, 4, 2);
        repeat (40) @(posedge clk);
        check_count(rx_cnt[port_east] - base, buf_depth, "flits sent without credit return");
        hold_port = -1;
        drain();
        $display("test 4 back-pressure: %0d errors", errors - mark);

        mark = errors;
        base = crd_pulses[port_north];
        @(negedge clk) credit_release_en[port_north] = 1'b1;
        @(negedge clk) credit_release_en[port_north] = 1'b0;
        repeat (12) @(posedge clk);
        rel_pulses[port_north] = crd_pulses[port_north] - base;
        up_crd[port_north] -= rel_pulses[port_north];   // not buffer slots
        check_count(rel_pulses[port_north], buf_depth, "release credits");
        $display("test 5 credit release: %0d errors", errors - mark);

        mark = errors;
        for (int i = 0; i < num_ports; i++) begin
            check_count(crd_pulses[i] - rel_pulses[i], wr_count[i],
                        $sformatf("credits returned on input %0d", i));
        end
        $display("test 6 credit balance: %0d errors", errors - mark);

        errors += UUT.u_assertions.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 UUT.u_assertions.fail_count);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
hdl/router_pkg.sv
hdl/input_port.sv
hdl/switch_alloc.sv
hdl/output_credit.sv
hdl/crossbar.sv
hdl/credit_release_gen.sv
hdl/router_two_stage.sv
bench/router_assertions.sv
bench/router_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = router_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
